/* rtl/matrix_calc_pkg.sv */
// ====================
// Matrix calculator shared definitions
// Limits, mode and error codes, received-byte view
// ====================
package matrix_calc_pkg;

    // ====================
    // Limits
    // ====================
    localparam int ELEM_W    = 8;
    localparam int DIM_W     = 4;
    localparam int MAX_DIM   = 4;
    localparam int MAX_VALUE = 9;
    localparam int NUM_SLOTS = 4;
    localparam int SLOT_W    = 2;
    // MAX_DIM squared elements per slot
    localparam int IDX_W     = 4;

    localparam logic [ELEM_W-1:0] END_MARK = 8'hFF;

    typedef enum logic [1:0] {
        MODE_MENU    = 2'd0,
        MODE_INPUT   = 2'd1,
        MODE_DISPLAY = 2'd2
    } mode_e;

    typedef enum logic [1:0] {
        ERR_NONE  = 2'd0,
        ERR_DIM   = 2'd1,
        ERR_VALUE = 2'd2
    } err_e;

    // Header byte, rows in the upper nibble
    typedef struct packed {
        logic [DIM_W-1:0] rows;
        logic [DIM_W-1:0] cols;
    } hdr_t;

    typedef union packed {
        hdr_t              hdr;
        logic [ELEM_W-1:0] value;
    } rx_byte_u;

endpackage

/* rtl/store_wr_if.sv */
// ====================
// Store write port
// Open, fill and commit or abort one matrix
// ====================
`timescale 1ns/1ps

interface store_wr_if;
    import matrix_calc_pkg::*;

    logic              open;
    logic [DIM_W-1:0]  rows;
    logic [DIM_W-1:0]  cols;
    logic              wr_en;
    logic [IDX_W-1:0]  wr_idx;
    logic [ELEM_W-1:0] wr_data;
    logic              commit;
    logic              abort;

    modport source (output open, rows, cols, wr_en, wr_idx, wr_data, commit, abort);
    modport sink   (input  open, rows, cols, wr_en, wr_idx, wr_data, commit, abort);

endinterface

/* rtl/store_rd_if.sv */
// ====================
// Store read port
// Slot query and element readback
// ====================
`timescale 1ns/1ps

interface store_rd_if;
    import matrix_calc_pkg::*;

    logic [SLOT_W-1:0] slot;
    logic              valid;
    logic [DIM_W-1:0]  rows;
    logic [DIM_W-1:0]  cols;
    logic              rd_en;
    logic [IDX_W-1:0]  rd_idx;
    logic [ELEM_W-1:0] rd_data;
    logic [SLOT_W:0]   count;

    modport source (output slot, rd_en, rd_idx, input valid, rows, cols, rd_data, count);
    modport sink   (input slot, rd_en, rd_idx, output valid, rows, cols, rd_data, count);

endinterface

/* rtl/button_debounce.sv */
// ====================
// Button debounce
// One pulse per press after a stable-high run
// ====================
`timescale 1ns/1ps

module button_debounce #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic pulse
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [1:0]       sync_q;
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
            cnt_q  <= '0;
            pulse  <= 1'b0;
        end else begin
            sync_q <= {sync_q[0], btn};
            // Count saturates so a held button fires only once
            if (!sync_q[1]) begin
                cnt_q <= '0;
            end else if (cnt_q != CNT_W'(DEBOUNCE_CYCLES)) begin
                cnt_q <= cnt_q + 1'b1;
            end
            pulse <= sync_q[1] && (cnt_q == CNT_W'(DEBOUNCE_CYCLES - 1));
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pulse |=> !pulse);

endmodule

/* rtl/mode_ctrl.sv */
// ====================
// Mode control
// Menu FSM selecting the active mode
// ====================
`timescale 1ns/1ps

module mode_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  confirm,
    input  logic                  back,
    input  logic [2:0]            dip_sw,
    output matrix_calc_pkg::mode_e mode
);
    import matrix_calc_pkg::*;

    mode_e mode_next;

    always_comb begin
        mode_next = mode;
        if (mode == MODE_MENU) begin
            if (confirm) begin
                case (dip_sw)
                    3'd1:    mode_next = MODE_INPUT;
                    3'd3:    mode_next = MODE_DISPLAY;
                    default: mode_next = MODE_MENU;
                endcase
            end
        end else if (back) begin
            mode_next = MODE_MENU;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

    a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        mode inside {MODE_MENU, MODE_INPUT, MODE_DISPLAY});

endmodule

/* rtl/matrix_store.sv */
// ====================
// Matrix store
// Four fixed slots with a slot table and element RAM
// Oldest slot is reused once all are full
// ====================
`timescale 1ns/1ps

module matrix_store (
    input logic      clk,
    input logic      rst_n,
    store_wr_if.sink wr,
    store_rd_if.sink rd
);
    import matrix_calc_pkg::*;

    localparam int RAM_DEPTH = NUM_SLOTS * (1 << IDX_W);

    logic [ELEM_W-1:0] ram [RAM_DEPTH];
    logic [DIM_W-1:0]  rows_q [NUM_SLOTS];
    logic [DIM_W-1:0]  cols_q [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] valid_q;
    logic [DIM_W-1:0]  pend_rows_q;
    logic [DIM_W-1:0]  pend_cols_q;
    logic [SLOT_W-1:0] wr_ptr_q;
    logic [SLOT_W:0]   count_q;
    logic              open_q;
    logic              do_commit;
    logic              do_abort;

    assign do_commit = wr.commit && open_q;
    assign do_abort  = wr.abort && open_q;

    // ====================
    // Slot table control
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            open_q   <= 1'b0;
        end else begin
            if (do_commit) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= wr_ptr_q + 1'b1;
                // Overwriting a valid slot keeps count at four
                if (!valid_q[wr_ptr_q]) begin
                    count_q <= count_q + 1'b1;
                end
                open_q <= 1'b0;
            end else if (do_abort) begin
                // Partial writes may have clobbered an older matrix here
                if (valid_q[wr_ptr_q]) begin
                    valid_q[wr_ptr_q] <= 1'b0;
                    count_q           <= count_q - 1'b1;
                end
                open_q <= 1'b0;
            end
            if (wr.open) begin
                open_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.open) begin
            pend_rows_q <= wr.rows;
            pend_cols_q <= wr.cols;
        end
        if (do_commit) begin
            rows_q[wr_ptr_q] <= pend_rows_q;
            cols_q[wr_ptr_q] <= pend_cols_q;
        end
    end

    // ====================
    // Element RAM
    // ====================
    always_ff @(posedge clk) begin
        if (wr.wr_en && open_q) begin
            ram[{wr_ptr_q, wr.wr_idx}] <= wr.wr_data;
        end
        if (rd.rd_en) begin
            rd.rd_data <= ram[{rd.slot, rd.rd_idx}];
        end
    end

    assign rd.valid = valid_q[rd.slot];
    assign rd.rows  = rows_q[rd.slot];
    assign rd.cols  = cols_q[rd.slot];
    assign rd.count = count_q;

    // Elements only between open and commit or abort
    a_wr_in_open: assert property (@(posedge clk) disable iff (!rst_n)
        wr.wr_en |-> open_q && !wr.open);

endmodule

/* rtl/matrix_input.sv */
// ====================
// Input mode
// Parses a header and element bytes, checks them, fills the store
// ====================
`timescale 1ns/1ps

module matrix_input #(
    parameter int MAX_DIM   = matrix_calc_pkg::MAX_DIM,
    parameter int MAX_VALUE = matrix_calc_pkg::MAX_VALUE
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  active,
    input  logic [7:0]            rx_data,
    input  logic                  rx_done,
    store_wr_if.source            wr,
    output matrix_calc_pkg::err_e error
);
    import matrix_calc_pkg::*;

    typedef enum logic [1:0] {
        S_HEAD,
        S_ELEM,
        S_HALT
    } state_e;

    state_e             state_q;
    err_e               error_q;
    rx_byte_u           byte_q;
    logic               byte_vld_q;
    logic               take;
    logic               dim_bad;
    logic               val_bad;
    logic               hdr_ok;
    logic               last_elem;
    logic [IDX_W-1:0]   idx_q;
    logic [2*DIM_W-1:0] n_elem_q;
    logic               commit_q;

    // Byte is handled the cycle after rx_done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_vld_q <= 1'b0;
        end else begin
            byte_vld_q <= rx_done && active;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            byte_q <= rx_data;
        end
    end

    assign take    = byte_vld_q && active;
    assign dim_bad = (byte_q.hdr.rows == '0) || (byte_q.hdr.cols == '0) ||
                     (byte_q.hdr.rows > MAX_DIM) || (byte_q.hdr.cols > MAX_DIM);
    assign val_bad = byte_q.value > MAX_VALUE;
    assign hdr_ok  = take && (state_q == S_HEAD) && !dim_bad;
    assign last_elem = {{(2*DIM_W-IDX_W){1'b0}}, idx_q} == (n_elem_q - 1'b1);

    // ====================
    // Store write strobes
    // ====================
    assign wr.open    = hdr_ok;
    assign wr.rows    = byte_q.hdr.rows;
    assign wr.cols    = byte_q.hdr.cols;
    assign wr.wr_en   = take && (state_q == S_ELEM) && !val_bad;
    assign wr.wr_idx  = idx_q;
    assign wr.wr_data = byte_q.value;
    assign wr.commit  = commit_q;
    assign wr.abort   = (state_q == S_ELEM) && (!active || (take && val_bad));
    assign error      = error_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= S_HEAD;
            error_q  <= ERR_NONE;
            idx_q    <= '0;
            commit_q <= 1'b0;
        end else begin
            commit_q <= 1'b0;
            if (!active) begin
                state_q <= S_HEAD;
                error_q <= ERR_NONE;
            end else if (take) begin
                case (state_q)
                    S_HEAD: begin
                        if (dim_bad) begin
                            error_q <= ERR_DIM;
                            state_q <= S_HALT;
                        end else begin
                            idx_q   <= '0;
                            state_q <= S_ELEM;
                        end
                    end
                    S_ELEM: begin
                        if (val_bad) begin
                            error_q <= ERR_VALUE;
                            state_q <= S_HEAD;
                        end else if (last_elem) begin
                            commit_q <= 1'b1;
                            state_q  <= S_HEAD;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                    // Bad header locks out input until the mode is left
                    default: state_q <= S_HALT;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_ok) begin
            n_elem_q <= byte_q.hdr.rows * byte_q.hdr.cols;
        end
    end

endmodule

/* rtl/matrix_display.sv */
// ====================
// Display mode
// Dumps every valid slot as bytes, then the end mark
// ====================
`timescale 1ns/1ps

module matrix_display (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       active,
    output logic [7:0] tx_data,
    output logic       tx_start,
    input  logic       tx_busy,
    store_rd_if.source rd
);
    import matrix_calc_pkg::*;

    typedef enum logic [2:0] {
        D_IDLE,
        D_SLOT,
        D_HDR,
        D_READ,
        D_ELEM,
        D_END,
        D_DONE
    } state_e;

    state_e             state_q;
    logic [SLOT_W-1:0]  slot_q;
    logic [IDX_W-1:0]   idx_q;
    logic [2*DIM_W-1:0] n_elem;
    logic               last_elem;
    logic               last_slot;
    logic               sent_q;
    logic               send_ok;

    // Dimensions stay on the read port while slot_q is held
    assign n_elem    = rd.rows * rd.cols;
    assign last_elem = {{(2*DIM_W-IDX_W){1'b0}}, idx_q} == (n_elem - 1'b1);
    assign last_slot = slot_q == SLOT_W'(NUM_SLOTS - 1);
    assign send_ok   = active && !tx_busy && !sent_q;

    assign rd.slot   = slot_q;
    assign rd.rd_en  = state_q == D_READ;
    assign rd.rd_idx = idx_q;

    always_comb begin
        tx_data  = END_MARK;
        tx_start = 1'b0;
        case (state_q)
            D_HDR: begin
                tx_data  = {rd.rows, rd.cols};
                tx_start = send_ok;
            end
            D_ELEM: begin
                tx_data  = rd.rd_data;
                tx_start = send_ok;
            end
            D_END: tx_start = send_ok;
            default: tx_start = 1'b0;
        endcase
    end

    // ====================
    // Dump sequencer
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= D_IDLE;
            slot_q  <= '0;
            idx_q   <= '0;
            sent_q  <= 1'b0;
        end else begin
            sent_q <= tx_start;
            if (!active) begin
                state_q <= D_IDLE;
            end else begin
                case (state_q)
                    D_IDLE: begin
                        slot_q  <= '0;
                        state_q <= (rd.count == '0) ? D_END : D_SLOT;
                    end
                    D_SLOT: begin
                        if (rd.valid) begin
                            state_q <= D_HDR;
                        end else if (last_slot) begin
                            state_q <= D_END;
                        end else begin
                            slot_q <= slot_q + 1'b1;
                        end
                    end
                    D_HDR: begin
                        if (send_ok) begin
                            idx_q   <= '0;
                            state_q <= D_READ;
                        end
                    end
                    D_READ: state_q <= D_ELEM;
                    D_ELEM: begin
                        if (send_ok) begin
                            if (!last_elem) begin
                                idx_q   <= idx_q + 1'b1;
                                state_q <= D_READ;
                            end else if (last_slot) begin
                                state_q <= D_END;
                            end else begin
                                slot_q  <= slot_q + 1'b1;
                                state_q <= D_SLOT;
                            end
                        end
                    end
                    D_END: begin
                        if (send_ok) begin
                            state_q <= D_DONE;
                        end
                    end
                    // Idle until the mode is re-entered
                    default: state_q <= D_DONE;
                endcase
            end
        end
    end

    // No start into a busy transmitter, no back-to-back starts
    a_tx_handshake: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy ##1 !tx_start);

endmodule

/* rtl/matrix_calc_top.sv */
// ====================
// Matrix calculator top level
// Buttons, menu, store, input and display modes
// ====================
`timescale 1ns/1ps

module matrix_calc_top #(
    parameter int DEBOUNCE_CYCLES = 1_000_000,
    parameter int MAX_DIM         = matrix_calc_pkg::MAX_DIM,
    parameter int MAX_VALUE       = matrix_calc_pkg::MAX_VALUE
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] dip_sw,
    input  logic       btn_confirm,
    input  logic       btn_back,
    input  logic [7:0] rx_data,
    input  logic       rx_done,
    input  logic       tx_busy,
    output logic [7:0] tx_data,
    output logic       tx_start,
    output logic [1:0] mode,
    output logic [1:0] error
);
    import matrix_calc_pkg::*;

    logic confirm_pulse;
    logic back_pulse;

    store_wr_if wr_bus ();
    store_rd_if rd_bus ();

    // ====================
    // Buttons and menu
    // ====================
    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_db_confirm (
        .clk  (clk),
        .rst_n(rst_n),
        .btn  (btn_confirm),
        .pulse(confirm_pulse)
    );

    button_debounce #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_db_back (
        .clk  (clk),
        .rst_n(rst_n),
        .btn  (btn_back),
        .pulse(back_pulse)
    );

    mode_ctrl u_mode_ctrl (
        .clk    (clk),
        .rst_n  (rst_n),
        .confirm(confirm_pulse),
        .back   (back_pulse),
        .dip_sw (dip_sw),
        .mode   (mode)
    );

    // ====================
    // Store and modes
    // ====================
    matrix_store u_store (
        .clk  (clk),
        .rst_n(rst_n),
        .wr   (wr_bus.sink),
        .rd   (rd_bus.sink)
    );

    // Error reads none outside input mode since input clears it on exit
    matrix_input #(
        .MAX_DIM  (MAX_DIM),
        .MAX_VALUE(MAX_VALUE)
    ) u_input (
        .clk    (clk),
        .rst_n  (rst_n),
        .active (mode == MODE_INPUT),
        .rx_data(rx_data),
        .rx_done(rx_done),
        .wr     (wr_bus.source),
        .error  (error)
    );

    matrix_display u_display (
        .clk     (clk),
        .rst_n   (rst_n),
        .active  (mode == MODE_DISPLAY),
        .tx_data (tx_data),
        .tx_start(tx_start),
        .tx_busy (tx_busy),
        .rd      (rd_bus.source)
    );

endmodule

/* verif/matrix_calc_tb.sv */
// ====================
// Matrix calculator testbench
// Directed tests with a transmitter model and a reference store
// ====================
`timescale 1ns/1ps

module matrix_calc_tb;
    import matrix_calc_pkg::*;

    logic       clk;
    logic       rst_n;
    logic [2:0] dip_sw;
    logic       btn_confirm;
    logic       btn_back;
    logic [7:0] rx_data;
    logic       rx_done;
    logic       tx_busy;
    logic [7:0] tx_data;
    logic       tx_start;
    logic [1:0] mode;
    logic [1:0] error;

    integer     seed;
    integer     busy_left;
    logic [7:0] tx_log [$];

    // Reference store, four slots and a write pointer
    logic       ref_valid [NUM_SLOTS];
    logic [3:0] ref_rows  [NUM_SLOTS];
    logic [3:0] ref_cols  [NUM_SLOTS];
    logic [7:0] ref_elem  [NUM_SLOTS][16];
    integer     ref_ptr;

    matrix_calc_top #(
        .DEBOUNCE_CYCLES(8)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .dip_sw     (dip_sw),
        .btn_confirm(btn_confirm),
        .btn_back   (btn_back),
        .rx_data    (rx_data),
        .rx_done    (rx_done),
        .tx_busy    (tx_busy),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .mode       (mode),
        .error      (error)
    );

    always #2 clk = ~clk;

    // ====================
    // Transmitter model
    // ====================
    // Busy for 1 to 5 cycles after each start
    always @(posedge clk) begin
        if (busy_left > 0) begin
            busy_left <= busy_left - 1;
            if (busy_left == 1) begin
                tx_busy <= 1'b0;
            end
        end else if (tx_start) begin
            tx_log.push_back(tx_data);
            busy_left <= 1 + $unsigned($random(seed)) % 5;
            tx_busy   <= 1'b1;
        end
    end

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    function automatic logic [7:0] make_header(input logic [3:0] rows, input logic [3:0] cols);
        rx_byte_u b;
        b.hdr.rows = rows;
        b.hdr.cols = cols;
        return b.value;
    endfunction

    // Hold a button, release it, then wait for the expected mode
    task automatic press(input logic use_back, input logic [2:0] sw,
                         input logic [1:0] want, input string name);
        integer t;
        @(posedge clk);
        dip_sw <= sw;
        if (use_back) begin
            btn_back <= 1'b1;
        end else begin
            btn_confirm <= 1'b1;
        end
        repeat (12) @(posedge clk);
        btn_confirm <= 1'b0;
        btn_back    <= 1'b0;
        t = 0;
        while (mode !== want && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (mode !== want) begin
            $display("Timeout in %s: mode never reached %0d", name, want);
            stop_with_failure();
        end
        // Let the synchroniser see the release
        repeat (4) @(posedge clk);
        check(name, want, mode);
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        rx_data <= b;
        rx_done <= 1'b1;
        @(posedge clk);
        rx_done <= 1'b0;
    endtask

    task automatic wait_error(input logic [1:0] want, input string name);
        integer t;
        t = 0;
        while (error !== want && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (error !== want) begin
            $display("Timeout in %s: error code stayed %0d instead of %0d", name, error, want);
            stop_with_failure();
        end
    endtask

    // Send one legal matrix and record it in the reference store
    task automatic enter_matrix(input logic [3:0] rows, input logic [3:0] cols);
        logic [7:0] v;
        integer     i;
        send_byte(make_header(rows, cols));
        for (i = 0; i < rows * cols; i++) begin
            v = $unsigned($random(seed)) % (MAX_VALUE + 1);
            ref_elem[ref_ptr][i] = v;
            send_byte(v);
        end
        ref_valid[ref_ptr] = 1'b1;
        ref_rows[ref_ptr]  = rows;
        ref_cols[ref_ptr]  = cols;
        ref_ptr            = (ref_ptr + 1) % NUM_SLOTS;
    endtask

    // Enter display mode and compare the dump with the reference store
    task automatic check_dump(input string name);
        logic [7:0] exp_q [$];
        integer     s;
        integer     i;
        integer     t;
        for (s = 0; s < NUM_SLOTS; s++) begin
            if (ref_valid[s]) begin
                exp_q.push_back({ref_rows[s], ref_cols[s]});
                for (i = 0; i < ref_rows[s] * ref_cols[s]; i++) begin
                    exp_q.push_back(ref_elem[s][i]);
                end
            end
        end
        exp_q.push_back(END_MARK);
        tx_log.delete();
        press(1'b0, 3'd3, MODE_DISPLAY, {name, " enter display"});
        t = 0;
        while (!(tx_log.size() > 0 && tx_log[tx_log.size() - 1] == END_MARK) && t < 3000) begin
            @(negedge clk);
            t++;
        end
        if (t >= 3000) begin
            $display("Timeout in %s: no end mark after %0d bytes", name, tx_log.size());
            stop_with_failure();
        end
        // Leaving first also catches stray bytes after the end mark
        press(1'b1, 3'd0, MODE_MENU, {name, " leave display"});
        check({name, " dump length"}, exp_q.size(), tx_log.size());
        for (i = 0; i < exp_q.size(); i++) begin
            check($sformatf("%s byte %0d", name, i), exp_q[i], tx_log[i]);
        end
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_reset();
        integer i;
        check("reset mode", MODE_MENU, mode);
        check("reset error", ERR_NONE, error);
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
            check("reset tx_start", 1'b0, tx_start);
        end
    endtask

    task automatic test_mode_select();
        press(1'b0, 3'd0, MODE_MENU, "select sw0 stays");
        press(1'b0, 3'd1, MODE_INPUT, "select input");
        press(1'b1, 3'd0, MODE_MENU, "back from input");
        press(1'b0, 3'd3, MODE_DISPLAY, "select display");
        press(1'b1, 3'd0, MODE_MENU, "back from display");
    endtask

    task automatic test_entry_dump();
        logic [3:0] rows;
        logic [3:0] cols;
        rows = 1 + $unsigned($random(seed)) % MAX_DIM;
        cols = 1 + $unsigned($random(seed)) % MAX_DIM;
        press(1'b0, 3'd1, MODE_INPUT, "entry enter input");
        enter_matrix(rows, cols);
        // Last element is taken the cycle after its rx_done
        repeat (2) @(posedge clk);
        check("entry error", ERR_NONE, error);
        press(1'b1, 3'd0, MODE_MENU, "entry leave input");
        check_dump("entry");
    endtask

    task automatic test_bad_dim();
        press(1'b0, 3'd1, MODE_INPUT, "bad dim enter");
        send_byte(make_header(4'd0, 4'd3));
        wait_error(ERR_DIM, "bad dim zero rows");
        // Bytes after a bad header are ignored
        send_byte(make_header(4'd1, 4'd1));
        send_byte(8'd5);
        press(1'b1, 3'd0, MODE_MENU, "bad dim leave");
        check("bad dim cleared", ERR_NONE, error);
        press(1'b0, 3'd1, MODE_INPUT, "bad dim reenter");
        send_byte(make_header(4'd2, 4'd5));
        wait_error(ERR_DIM, "bad dim five cols");
        press(1'b1, 3'd0, MODE_MENU, "bad dim leave again");
        check_dump("bad dim");
    endtask

    task automatic test_bad_value();
        press(1'b0, 3'd1, MODE_INPUT, "bad value enter");
        send_byte(make_header(4'd2, 4'd2));
        send_byte(8'd4);
        send_byte(8'd10 + $unsigned($random(seed)) % 200);
        wait_error(ERR_VALUE, "bad value");
        press(1'b1, 3'd0, MODE_MENU, "bad value leave");
        check("bad value cleared", ERR_NONE, error);
        // The aborted slot is discarded
        ref_valid[ref_ptr] = 1'b0;
        check_dump("bad value");
    endtask

    // One matrix is already stored, four more make five
    task automatic test_overwrite();
        integer n;
        press(1'b0, 3'd1, MODE_INPUT, "overwrite enter");
        for (n = 0; n < 4; n++) begin
            enter_matrix(1 + $unsigned($random(seed)) % MAX_DIM,
                         1 + $unsigned($random(seed)) % MAX_DIM);
        end
        press(1'b1, 3'd0, MODE_MENU, "overwrite leave");
        check_dump("overwrite");
    endtask

    task automatic init_reference();
        integer s;
        ref_ptr = 0;
        for (s = 0; s < NUM_SLOTS; s++) begin
            ref_valid[s] = 1'b0;
        end
    endtask

    initial begin
        seed        = 59244;
        clk         = 1'b0;
        rst_n       = 1'b0;
        dip_sw      = 3'd0;
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        rx_data     = 8'd0;
        rx_done     = 1'b0;
        tx_busy     = 1'b0;
        busy_left   = 0;
        init_reference();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_mode_select();
        test_entry_dump();
        test_bad_dim();
        test_bad_value();
        test_overwrite();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* matrix_calc_top.f */
rtl/matrix_calc_pkg.sv
rtl/store_wr_if.sv
rtl/store_rd_if.sv
rtl/button_debounce.sv
rtl/mode_ctrl.sv
rtl/matrix_store.sv
rtl/matrix_input.sv
rtl/matrix_display.sv
rtl/matrix_calc_top.sv
verif/matrix_calc_tb.sv

/* Bender.yml */
package:
  name: matrix_calc

sources:
  - files:
      - rtl/matrix_calc_pkg.sv
      - rtl/store_wr_if.sv
      - rtl/store_rd_if.sv
      - rtl/button_debounce.sv
      - rtl/mode_ctrl.sv
      - rtl/matrix_store.sv
      - rtl/matrix_input.sv
      - rtl/matrix_display.sv
      - rtl/matrix_calc_top.sv
  - target: simulation
    files:
      - verif/matrix_calc_tb.sv
